// File: logic/kbd_pkg.sv
/* PS/2 keyboard shared types and constants */

package kbd_pkg;

  // --------------------------------------------------
  // Key event as queued and read over APB
  // --------------------------------------------------

  typedef struct packed {
    logic       ext;   // Code came after an E0 prefix
    logic       rel;   // Code came after an F0 prefix
    logic [7:0] code;  // Raw scan code
  } key_event_t;

  // STATUS register layout, avail in bit 0
  typedef struct packed {
    logic frame_err;   // Sticky, bad stop bit seen
    logic parity_err;  // Sticky, bad parity seen
    logic overflow;    // Sticky, event lost to a full FIFO
    logic avail;       // FIFO holds at least one event
  } status_t;

  // --------------------------------------------------
  // Event FIFO sizing
  // --------------------------------------------------

  localparam int KEY_FIFO_DEPTH = 8;
  localparam int KEY_FIFO_AW    = 3;

  // --------------------------------------------------
  // APB register map
  // --------------------------------------------------

  localparam int APB_AW = 4;

  localparam logic [APB_AW-1:0] REG_STATUS = 4'h0;
  localparam logic [APB_AW-1:0] REG_DATA   = 4'h4;
  localparam logic [APB_AW-1:0] REG_CTRL   = 4'h8;

  // --------------------------------------------------
  // Scan code prefixes
  // --------------------------------------------------

  localparam logic [7:0] PREFIX_EXT = 8'hE0;
  localparam logic [7:0] PREFIX_REL = 8'hF0;

endpackage

// File: logic/ps2_sync.sv
/* PS/2 pin synchronizer and clock edge detect */

module ps2_sync (
  input  logic clk,
  input  logic rst,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic data_sync,
  output logic fall
);

  // Two-flop chains for both pins
  logic clk_meta;
  logic clk_sync;
  logic clk_prev;
  logic data_meta;

  // Lines idle high, so preset high and no edge fires after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
      fall      <= 1'b0;
    end else begin
      clk_meta  <= ps2_clk;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= ps2_data;
      data_sync <= data_meta;
      // Registered high-to-low detect on the synced clock
      fall      <= clk_prev & ~clk_sync;
    end
  end

endmodule

// File: logic/ps2_frame_rx.sv
/* PS/2 eleven-bit frame receiver */

module ps2_frame_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       data_sync,
  input  logic       fall,
  output logic       byte_valid,
  output logic [7:0] byte_data,
  output logic       parity_err,
  output logic       frame_err
);

  // --------------------------------------------------
  // Frame state
  // --------------------------------------------------

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_t;

  rx_state_t  state;
  logic [2:0] bit_cnt;
  logic [7:0] data_sr;
  logic       par_acc;
  logic       par_ok;

  // Shift register doubles as the byte output
  assign byte_data = data_sr;

  // --------------------------------------------------
  // Sequencing, one step per PS/2 falling edge
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      bit_cnt    <= 3'd0;
      par_acc    <= 1'b0;
      par_ok     <= 1'b0;
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      // Result strobes are single-cycle
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
      if (fall) begin
        case (state)
          ST_IDLE: begin
            // Start bit must be low
            if (!data_sync) begin
              state   <= ST_DATA;
              bit_cnt <= 3'd0;
              par_acc <= 1'b0;
            end
          end
          ST_DATA: begin
            par_acc <= par_acc ^ data_sync;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= ST_PARITY;
            end
          end
          ST_PARITY: begin
            // Odd parity over data plus parity bit
            par_ok <= par_acc ^ data_sync;
            state  <= ST_STOP;
          end
          ST_STOP: begin
            state <= ST_IDLE;
            // Stop bit fault takes priority, one strobe per frame
            if (!data_sync) begin
              frame_err <= 1'b1;
            end else if (!par_ok) begin
              parity_err <= 1'b1;
            end else begin
              byte_valid <= 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (fall && state == ST_DATA) begin
      data_sr <= {data_sync, data_sr[7:1]};
    end
  end

endmodule

// File: logic/scan_decoder.sv
/* Scan code prefix decoder */

module scan_decoder (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  logic               byte_valid,
  input  logic [7:0]         byte_data,
  output logic               evt_valid,
  output kbd_pkg::key_event_t evt
);

  import kbd_pkg::*;

  // --------------------------------------------------
  // Pending prefix flags
  // --------------------------------------------------

  logic ext_pend;
  logic rel_pend;
  logic is_ext;
  logic is_rel;

  assign is_ext = (byte_data == PREFIX_EXT);
  assign is_rel = (byte_data == PREFIX_REL);

  always_ff @(posedge clk) begin
    if (rst) begin
      ext_pend  <= 1'b0;
      rel_pend  <= 1'b0;
      evt_valid <= 1'b0;
    end else begin
      evt_valid <= 1'b0;
      if (!enable) begin
        // Disabled, drop bytes and forget any half-seen sequence
        ext_pend <= 1'b0;
        rel_pend <= 1'b0;
      end else if (byte_valid) begin
        if (is_ext) begin
          ext_pend <= 1'b1;
        end else if (is_rel) begin
          rel_pend <= 1'b1;
        end else begin
          // Plain code ends the sequence
          evt_valid <= 1'b1;
          ext_pend  <= 1'b0;
          rel_pend  <= 1'b0;
        end
      end
    end
  end

  // --------------------------------------------------
  // Event payload
  // --------------------------------------------------

  // Latched alongside evt_valid, flags taken before they clear
  always_ff @(posedge clk) begin
    if (enable && byte_valid && !is_ext && !is_rel) begin
      evt.ext  <= ext_pend;
      evt.rel  <= rel_pend;
      evt.code <= byte_data;
    end
  end

endmodule

// File: logic/key_fifo.sv
/* Key event FIFO */

module key_fifo (
  input  logic               clk,
  input  logic               rst,
  input  logic               push,
  input  kbd_pkg::key_event_t din,
  input  logic               pop,
  output kbd_pkg::key_event_t head,
  output logic               empty,
  output logic               overflow
);

  import kbd_pkg::*;

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------

  key_event_t mem [KEY_FIFO_DEPTH];

  logic [KEY_FIFO_AW-1:0] wptr;
  logic [KEY_FIFO_AW-1:0] rptr;
  logic [KEY_FIFO_AW:0]   count;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;

  assign empty = (count == '0);
  assign full  = (count == (KEY_FIFO_AW + 1)'(KEY_FIFO_DEPTH));

  // A pop frees a slot for a push in the same cycle
  assign do_pop  = pop & ~empty;
  assign do_push = push & (~full | do_pop);

  // Oldest entry
  assign head = mem[rptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr     <= '0;
      rptr     <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Dropped push
      overflow <= push & ~do_push;
      // Pointers wrap at the power-of-two depth
      if (do_push) begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wptr] <= din;
    end
  end

endmodule

// File: logic/kbd_apb_regs.sv
/* APB register block for the keyboard */

module kbd_apb_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [kbd_pkg::APB_AW-1:0] paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pslverr,
  input  logic                       empty,
  input  kbd_pkg::key_event_t        head,
  input  logic                       overflow,
  input  logic                       parity_err,
  input  logic                       frame_err,
  output logic                       pop,
  output logic                       enable
);

  import kbd_pkg::*;

  // --------------------------------------------------
  // Access decode
  // --------------------------------------------------

  logic acc;
  logic rd;
  logic wr;
  logic hit_status;
  logic hit_data;
  logic hit_ctrl;

  // Zero wait states, access phase completes at once
  assign acc = psel & penable;
  assign rd  = acc & ~pwrite;
  assign wr  = acc & pwrite;

  assign hit_status = (paddr == REG_STATUS);
  assign hit_data   = (paddr == REG_DATA);
  assign hit_ctrl   = (paddr == REG_CTRL);

  // Anything off the map, misaligned offsets too
  assign pslverr = acc & ~(hit_status | hit_data | hit_ctrl);

  // Head leaves on a DATA read only if there is one
  assign pop = rd & hit_data & ~empty;

  // --------------------------------------------------
  // Sticky error flags
  // --------------------------------------------------

  logic    ovf_flag;
  logic    par_flag;
  logic    frm_flag;
  status_t status;
  status_t wclr;

  assign wclr = status_t'(pwdata[$bits(status_t)-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      ovf_flag <= 1'b0;
      par_flag <= 1'b0;
      frm_flag <= 1'b0;
    end else begin
      // New event wins over a clear in the same cycle
      if (overflow) begin
        ovf_flag <= 1'b1;
      end else if (wr && hit_status && wclr.overflow) begin
        ovf_flag <= 1'b0;
      end
      if (parity_err) begin
        par_flag <= 1'b1;
      end else if (wr && hit_status && wclr.parity_err) begin
        par_flag <= 1'b0;
      end
      if (frame_err) begin
        frm_flag <= 1'b1;
      end else if (wr && hit_status && wclr.frame_err) begin
        frm_flag <= 1'b0;
      end
    end
  end

  always_comb begin
    status.avail      = ~empty;
    status.overflow   = ovf_flag;
    status.parity_err = par_flag;
    status.frame_err  = frm_flag;
  end

  // --------------------------------------------------
  // CTRL
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (wr && hit_ctrl) begin
      enable <= pwdata[0];
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------

  always_comb begin
    prdata = '0;
    if (rd) begin
      if (hit_status) begin
        prdata = 32'(status);
      end else if (hit_data && !empty) begin
        // Valid flag sits just above the event
        prdata = 32'({1'b1, head});
      end else if (hit_ctrl) begin
        prdata = 32'(enable);
      end
    end
  end

endmodule

// File: logic/ps2_kbd_top.sv
/* PS/2 keyboard subsystem top */

module ps2_kbd_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ps2_clk,
  input  logic                       ps2_data,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [kbd_pkg::APB_AW-1:0] paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pslverr
);

  import kbd_pkg::*;

  // --------------------------------------------------
  // Inter-stage signals
  // --------------------------------------------------

  logic       data_sync;
  logic       fall;
  logic       byte_valid;
  logic [7:0] byte_data;
  logic       parity_err;
  logic       frame_err;
  logic       enable;
  logic       evt_valid;
  key_event_t evt;
  key_event_t head;
  logic       empty;
  logic       overflow;
  logic       pop;

  // Pins to synced data and clock fall strobe
  ps2_sync u_sync (
    .clk       (clk),
    .rst       (rst),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .data_sync (data_sync),
    .fall      (fall)
  );

  ps2_frame_rx u_frame_rx (
    .clk        (clk),
    .rst        (rst),
    .data_sync  (data_sync),
    .fall       (fall),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  scan_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .evt_valid  (evt_valid),
    .evt        (evt)
  );

  key_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (evt_valid),
    .din      (evt),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  // CPU side
  kbd_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .empty      (empty),
    .head       (head),
    .overflow   (overflow),
    .parity_err (parity_err),
    .frame_err  (frame_err),
    .pop        (pop),
    .enable     (enable)
  );

endmodule

// File: dv/ps2_kbd_tb.sv
/* PS/2 keyboard subsystem testbench */

module ps2_kbd_tb;

  import kbd_pkg::*;

  // Frames per test at worst, three per event when both prefixes come
  localparam int     FRAME_BUDGET  = 200 * 3 + 2 + 10 * 3 + 14;
  localparam longint WATCHDOG_TIME = longint'(FRAME_BUDGET) * 11 * 24 * 20 + 20000;
  localparam int     PS2_HALF      = 12;  // clk cycles per PS/2 half period

  logic              clk;
  logic              rst;
  logic              ps2_clk;
  logic              ps2_data;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pslverr;

  // Reference model state
  key_event_t exp_q[$];   // Expected FIFO contents, oldest first
  logic       m_ext;
  logic       m_rel;
  logic       m_en;
  status_t    m_stat;     // Sticky bits only, avail comes from the queue

  ps2_kbd_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pslverr  (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    report_failure("timeout, the tests did not finish in the expected time");
  end

  // --------------------------------------------------
  // Failure reporting and compares
  // --------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_event(input string name, input key_event_t got, input key_event_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // PS/2 device model
  // --------------------------------------------------

  // Start, 8 data LSB first, odd parity, stop
  task automatic send_frame(input logic [7:0] b, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, ~(^b) ^ bad_par, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      // Data moves only while the PS/2 clock is high
      @(posedge clk);
      ps2_data <= bits[i];
      repeat (PS2_HALF - 1) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    // Back to idle, then a gap
    @(posedge clk);
    ps2_data <= 1'b1;
    repeat (PS2_HALF) @(posedge clk);
  endtask

  // Prefix tracking as the keyboard protocol defines it
  task automatic model_byte(input logic [7:0] b);
    key_event_t e;
    if (!m_en) begin
      m_ext = 1'b0;
      m_rel = 1'b0;
    end else if (b == 8'hE0) begin
      m_ext = 1'b1;
    end else if (b == 8'hF0) begin
      m_rel = 1'b1;
    end else begin
      e.ext  = m_ext;
      e.rel  = m_rel;
      e.code = b;
      // Full queue loses the new event
      if (exp_q.size() < KEY_FIFO_DEPTH) begin
        exp_q.push_back(e);
      end else begin
        m_stat.overflow = 1'b1;
      end
      m_ext = 1'b0;
      m_rel = 1'b0;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    send_frame(b, 1'b0, 1'b0);
    model_byte(b);
  endtask

  // Random code with none, E0, F0 or both in front
  task automatic send_random_key();
    logic [7:0] code;
    logic [1:0] sel;
    code = 8'($urandom_range(255));
    if (code == 8'hE0 || code == 8'hF0) begin
      code = code ^ 8'h01;
    end
    sel = 2'($urandom_range(3));
    if (sel[0]) begin
      send_byte(8'hE0);
    end
    if (sel[1]) begin
      send_byte(8'hF0);
    end
    send_byte(code);
  endtask

  // --------------------------------------------------
  // APB driver
  // --------------------------------------------------

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    // Mid access phase, read data is settled
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic expect_status();
    logic [31:0] rd;
    logic        err;
    status_t     exp;
    exp       = m_stat;
    exp.avail = (exp_q.size() != 0);
    apb_read(REG_STATUS, rd, err);
    check_status("status", status_t'(rd[$bits(status_t)-1:0]), exp);
    check_word("pslverr", {31'b0, err}, 32'h0);
  endtask

  // One DATA read, popped against the model
  task automatic read_data_check();
    logic [31:0] rd;
    logic        err;
    apb_read(REG_DATA, rd, err);
    check_word("pslverr", {31'b0, err}, 32'h0);
    if (exp_q.size() == 0) begin
      check_word("data", rd, 32'h0);
    end else begin
      check_word("data valid", {31'b0, rd[$bits(key_event_t)]}, 32'h1);
      check_event("data event", key_event_t'(rd[$bits(key_event_t)-1:0]), exp_q.pop_front());
    end
  endtask

  task automatic wait_avail();
    logic [31:0] rd;
    logic        err;
    status_t     st;
    for (int n = 0; n < 40; n++) begin
      apb_read(REG_STATUS, rd, err);
      st = status_t'(rd[$bits(status_t)-1:0]);
      if (st.avail) begin
        return;
      end
    end
    report_failure("no key event became available in STATUS");
  endtask

  task automatic write_ctrl(input logic en);
    apb_write(REG_CTRL, {31'b0, en});
    m_en = en;
    if (!en) begin
      m_ext = 1'b0;
      m_rel = 1'b0;
    end
  endtask

  task automatic clear_sticky();
    apb_write(REG_STATUS, 32'hF);
    m_stat = '0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    logic [31:0] rd;
    logic        err;
    rst      = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    m_ext    = 1'b0;
    m_rel    = 1'b0;
    m_en     = 1'b0;
    m_stat   = '0;
    void'($urandom(45));
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Reset values, CTRL access, unmapped offset
    expect_status();
    apb_read(REG_CTRL, rd, err);
    check_word("ctrl", rd, 32'h0);
    write_ctrl(1'b1);
    apb_read(REG_CTRL, rd, err);
    check_word("ctrl", rd, 32'h1);
    apb_read(4'hC, rd, err);
    check_word("pslverr", {31'b0, err}, 32'h1);

    // Random events one at a time
    repeat (200) begin
      send_random_key();
      wait_avail();
      read_data_check();
      expect_status();
    end

    // Bad parity, then bad stop bit
    send_frame(8'h1C, 1'b1, 1'b0);
    m_stat.parity_err = 1'b1;
    expect_status();
    send_frame(8'h1C, 1'b0, 1'b1);
    m_stat.frame_err = 1'b1;
    expect_status();
    clear_sticky();
    expect_status();

    // Ten events into an eight deep FIFO
    repeat (10) send_random_key();
    expect_status();
    repeat (9) read_data_check();
    clear_sticky();
    expect_status();

    // Release prefix left pending, then decoder off
    send_byte(8'hF0);
    write_ctrl(1'b0);
    send_byte(8'hE0);
    send_byte(8'h2A);
    send_byte(8'hF0);
    expect_status();
    write_ctrl(1'b1);
    send_byte(8'h2A);
    wait_avail();
    read_data_check();
    repeat (3) begin
      send_random_key();
      wait_avail();
      read_data_check();
    end
    expect_status();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: all.f
logic/kbd_pkg.sv
logic/ps2_sync.sv
logic/ps2_frame_rx.sv
logic/scan_decoder.sv
logic/key_fifo.sv
logic/kbd_apb_regs.sv
logic/ps2_kbd_top.sv
dv/ps2_kbd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ps2_kbd_tb -f all.f -o ps2_kbd_sim \
  || { echo "build error"; exit 1; }

./obj_dir/ps2_kbd_sim > sim.log 2>&1
cat sim.log

# The log decides the result
grep -q "Test failed" sim.log && exit 1 || grep -q "Test completed successfully" sim.log || exit 1
exit 0
